// ==== build.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/reg_file.sv
hdl/operand_fetch.sv
hdl/rv_alu.sv
hdl/retire_stage.sv
hdl/rv_exec_core.sv
sim/rv_exec_core_tb.sv

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_fetch (
  input  logic              clk,
  input  logic              reset,
  input  logic              inst_valid,
  input  rv_pkg::decoded_t  dec,
  input  rv_pkg::xlen_t     alu_result,
  input  logic              wr_en,
  input  rv_pkg::reg_idx_t  wr_idx,
  input  rv_pkg::xlen_t     wr_data,
  output rv_pkg::xlen_t     pc,
  output rv_pkg::ex_stage_t ex
);
  import rv_pkg::*;

  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t rs1_val;
  xlen_t rs2_val;
  xlen_t op_a;
  xlen_t op_b;
  logic  fwd_ok;

  reg_file rf0 (
    .clk      (clk),
    .reset    (reset),
    .rs1_idx  (dec.rs1_idx),
    .rs2_idx  (dec.rs2_idx),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_data  (wr_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (inst_valid) begin
      pc <= pc + 64'd4;
    end
  end

  // the instruction in execute has not written back yet
  assign fwd_ok  = ex.valid && ex.dec.inst_class == cls_alu && ex.dec.rd_idx != '0;
  assign rs1_val = (fwd_ok && ex.dec.rd_idx == dec.rs1_idx) ? alu_result : rs1_data;
  assign rs2_val = (fwd_ok && ex.dec.rd_idx == dec.rs2_idx) ? alu_result : rs2_data;

  assign op_a = dec.use_pc ? dec.pc : rs1_val;
  assign op_b = dec.use_imm ? dec.imm : rs2_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= inst_valid;
    end
    if (inst_valid) begin
      ex.dec  <= dec;
      ex.op_a <= op_a;
      ex.op_b <= op_b;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::xlen_t    wr_data,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data
);
  import rv_pkg::*;

  xlen_t regs [reg_count];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  // retire gating must already have dropped writes to x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> wr_idx != '0);

endmodule

`default_nettype wire

// ==== hdl/retire_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_stage (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::ex_stage_t ex,
  input  rv_pkg::xlen_t     result,
  output logic              wr_en,
  output rv_pkg::reg_idx_t  wr_idx,
  output rv_pkg::xlen_t     wr_data,
  output logic              retire_valid,
  output rv_pkg::retire_t   retire
);
  import rv_pkg::*;

  logic is_alu;

  assign is_alu  = ex.dec.inst_class == cls_alu;
  assign wr_en   = ex.valid && is_alu && ex.dec.rd_idx != '0;
  assign wr_idx  = ex.dec.rd_idx;
  assign wr_data = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ex.valid;
    end
  end

  // unsupported and illegal retire with no destination and no value
  always_ff @(posedge clk) begin
    if (ex.valid) begin
      retire.pc         <= ex.dec.pc;
      retire.inst_class <= ex.dec.inst_class;
      retire.rd_idx     <= is_alu ? ex.dec.rd_idx : '0;
      retire.value      <= is_alu ? result : '0;
    end
  end

  a_retire_valid_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(retire_valid));

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  rv_pkg::ex_stage_t ex,
  output rv_pkg::xlen_t     result
);
  import rv_pkg::*;

  xlen_t                    a;
  xlen_t                    b;
  logic [shamt_width-1:0]   shamt;
  logic [shamt_w_width-1:0] shamt_w;
  logic [word_len-1:0]      word;
  logic                     is_word;

  assign a       = ex.op_a;
  assign b       = ex.op_b;
  assign shamt   = b[shamt_width-1:0];
  assign shamt_w = b[shamt_w_width-1:0];
  assign is_word = ex.dec.alu_op inside {addw, subw, sllw, srlw, sraw};

  always_comb begin
    result = '0;
    word   = '0;
    case (ex.dec.alu_op)
      add:    result = a + b;
      sub:    result = a - b;
      sll:    result = a << shamt;
      slt:    result = xlen_t'($signed(a) < $signed(b));
      sltu:   result = xlen_t'(a < b);
      xor_op: result = a ^ b;
      srl:    result = a >> shamt;
      sra:    result = $signed(a) >>> shamt;
      or_op:  result = a | b;
      and_op: result = a & b;
      // word ops only look at the low half
      addw:   word = a[word_len-1:0] + b[word_len-1:0];
      subw:   word = a[word_len-1:0] - b[word_len-1:0];
      sllw:   word = a[word_len-1:0] << shamt_w;
      srlw:   word = a[word_len-1:0] >> shamt_w;
      sraw:   word = $signed(a[word_len-1:0]) >>> shamt_w;
      pass_b: result = b;
      default: ;
    endcase
    if (is_word) begin
      result = {{(xlen - word_len){word[word_len-1]}}, word};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
  input  rv_pkg::inst_t    inst_data,
  input  rv_pkg::xlen_t    pc,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift_alt;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       is_alu;
  logic       is_unsup;
  logic       need_rs1;
  logic       need_rs2;
  logic       need_rd;

  function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? sub : add;
      3'b001:  return sll;
      3'b010:  return slt;
      3'b011:  return sltu;
      3'b100:  return xor_op;
      3'b101:  return alt ? sra : srl;
      3'b110:  return or_op;
      default: return and_op;
    endcase
  endfunction

  // word forms of the ops that have one
  function automatic alu_op_e word_op(input alu_op_e base);
    case (base)
      add:     return addw;
      sub:     return subw;
      sll:     return sllw;
      srl:     return srlw;
      sra:     return sraw;
      default: return base;
    endcase
  endfunction

  assign opcode = opcode_e'(inst_data[6:0]);
  assign funct3 = inst_data[14:12];
  assign funct7 = inst_data[31:25];
  // srai and sraiw select the arithmetic shift with bit 30
  assign shift_alt = (funct3 == 3'b101) && inst_data[30];

  assign imm_i = {{52{inst_data[31]}}, inst_data[31:20]};
  assign imm_s = {{52{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
  assign imm_b = {{51{inst_data[31]}}, inst_data[31], inst_data[7], inst_data[30:25],
                  inst_data[11:8], 1'b0};
  assign imm_u = {{32{inst_data[31]}}, inst_data[31:12], 12'b0};
  assign imm_j = {{43{inst_data[31]}}, inst_data[31], inst_data[19:12], inst_data[20],
                  inst_data[30:21], 1'b0};

  always_comb begin
    is_alu     = 1'b0;
    is_unsup   = 1'b0;
    need_rs1   = 1'b0;
    need_rs2   = 1'b0;
    need_rd    = 1'b0;
    dec        = '0;
    dec.pc     = pc;
    dec.alu_op = add;
    case (opcode)
      lui, auipc: begin
        is_alu      = 1'b1;
        need_rd     = 1'b1;
        dec.use_imm = 1'b1;
        dec.use_pc  = (opcode == auipc);
        dec.imm     = imm_u;
        dec.alu_op  = (opcode == lui) ? pass_b : add;
      end
      op_imm, op_imm_32: begin
        need_rs1    = 1'b1;
        need_rd     = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        dec.alu_op  = base_op(funct3, shift_alt);
        // rv64 shifts keep funct7[0] as shamt[5] but word shifts do not
        case (funct3)
          3'b001:  is_alu = (opcode == op_imm) ? (funct7[6:1] == 6'b000000)
                                               : (funct7 == 7'b0000000);
          3'b101:  is_alu = (opcode == op_imm) ?
                            (funct7[6:1] == 6'b000000 || funct7[6:1] == 6'b010000) :
                            (funct7 == 7'b0000000 || funct7 == 7'b0100000);
          default: is_alu = (opcode == op_imm) || (funct3 == 3'b000);
        endcase
        if (opcode == op_imm_32) begin
          dec.alu_op = word_op(dec.alu_op);
        end
      end
      op, op_32: begin
        need_rs1   = 1'b1;
        need_rs2   = 1'b1;
        need_rd    = 1'b1;
        dec.alu_op = base_op(funct3, funct7[5]);
        if (funct7 == 7'b0000001) begin
          // M extension is legal but not executed here
          is_unsup = (opcode == op) || (funct3 == 3'b000) || funct3[2];
        end else if (funct7 == 7'b0000000 ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          is_alu = (opcode == op) || (funct3 inside {3'b000, 3'b001, 3'b101});
        end
        if (opcode == op_32) begin
          dec.alu_op = word_op(dec.alu_op);
        end
      end
      load, jalr: begin
        is_unsup = 1'b1;
        need_rs1 = 1'b1;
        need_rd  = 1'b1;
        dec.imm  = imm_i;
      end
      store, branch: begin
        is_unsup = 1'b1;
        need_rs1 = 1'b1;
        need_rs2 = 1'b1;
        dec.imm  = (opcode == store) ? imm_s : imm_b;
      end
      jal: begin
        is_unsup = 1'b1;
        need_rd  = 1'b1;
        dec.imm  = imm_j;
      end
      system, misc_mem: is_unsup = 1'b1;
      default: ;
    endcase

    dec.rs1_idx    = need_rs1 ? inst_data[19:15] : '0;
    dec.rs2_idx    = need_rs2 ? inst_data[24:20] : '0;
    dec.rd_idx     = need_rd ? inst_data[11:7] : '0;
    dec.inst_class = is_alu ? cls_alu : (is_unsup ? cls_unsupported : cls_illegal);

    // an executed 32-bit opcode must map to a word op and no other opcode may
    if (!$isunknown(inst_data) && dec.inst_class == cls_alu) begin
      assert ((opcode inside {op_imm_32, op_32}) ==
              (dec.alu_op inside {addw, subw, sllw, srlw, sraw}))
        else $error("word opcode and alu op disagree for %h", inst_data);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_exec_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_exec_core (
  input  logic            clk,
  input  logic            reset,
  input  logic            inst_valid,
  input  rv_pkg::inst_t   inst_data,
  output logic            retire_valid,
  output rv_pkg::retire_t retire
);
  import rv_pkg::*;

  decoded_t  dec;
  xlen_t     pc;
  ex_stage_t ex;
  xlen_t     alu_result;
  logic      wr_en;
  reg_idx_t  wr_idx;
  xlen_t     wr_data;

  rv_decode decode0 (
    .inst_data (inst_data),
    .pc        (pc),
    .dec       (dec)
  );

  operand_fetch fetch0 (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .dec        (dec),
    .alu_result (alu_result),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_data    (wr_data),
    .pc         (pc),
    .ex         (ex)
  );

  rv_alu alu0 (
    .ex     (ex),
    .result (alu_result)
  );

  retire_stage retire0 (
    .clk          (clk),
    .reset        (reset),
    .ex           (ex),
    .result       (alu_result),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_data      (wr_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen           = 64;
  localparam int inst_len       = 32;
  localparam int reg_addr_width = 5;
  localparam int reg_count      = 1 << reg_addr_width;
  localparam int word_len       = 32;
  localparam int shamt_width    = 6;
  localparam int shamt_w_width  = 5;

  localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;

  typedef logic [xlen-1:0]           xlen_t;
  typedef logic [inst_len-1:0]       inst_t;
  typedef logic [reg_addr_width-1:0] reg_idx_t;

  // major opcodes in bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,
    op        = 7'b0110011,
    op_imm_32 = 7'b0011011,
    op_32     = 7'b0111011,
    lui       = 7'b0110111,
    auipc     = 7'b0010111,
    load      = 7'b0000011,
    store     = 7'b0100011,
    branch    = 7'b1100011,
    jal       = 7'b1101111,
    jalr      = 7'b1100111,
    system    = 7'b1110011,
    misc_mem  = 7'b0001111
  } opcode_e;

  typedef enum logic [1:0] {
    cls_alu,
    cls_unsupported,
    cls_illegal
  } inst_class_e;

  typedef enum logic [4:0] {
    add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op,
    addw, subw, sllw, srlw, sraw,
    // lui result is the immediate itself
    pass_b
  } alu_op_e;

  typedef struct packed {
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    reg_idx_t    rd_idx;
    xlen_t       imm;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        use_pc;
    inst_class_e inst_class;
    xlen_t       pc;
  } decoded_t;

  // operands as the alu sees them with the bypass already applied
  typedef struct packed {
    logic     valid;
    decoded_t dec;
    xlen_t    op_a;
    xlen_t    op_b;
  } ex_stage_t;

  typedef struct packed {
    xlen_t       pc;
    inst_class_e inst_class;
    reg_idx_t    rd_idx;
    xlen_t       value;
  } retire_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the rv_exec_core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module rv_exec_core_tb -Mdir "$obj"; then
  echo "verilator compile failed"
  exit 1
fi

"./$obj/Vrv_exec_core_tb" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "test failed" "$log"; then
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "test passed" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

// ==== include/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

function automatic rv_pkg::xlen_t ref_sext32(input logic [31:0] w);
  return {{32{w[31]}}, w};
endfunction

// one integer operation by funct3, full width or word form
function automatic rv_pkg::xlen_t ref_op(input logic [2:0] f3, input logic alt,
                                         input logic word, input rv_pkg::xlen_t a,
                                         input rv_pkg::xlen_t b);
  if (word) begin
    case (f3)
      3'b000:  return ref_sext32(alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0]);
      3'b001:  return ref_sext32(a[31:0] << b[4:0]);
      default: return ref_sext32(alt ? $unsigned($signed(a[31:0]) >>> b[4:0])
                                     : a[31:0] >> b[4:0]);
    endcase
  end
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[5:0];
    3'b010:  return {63'b0, $signed(a) < $signed(b)};
    3'b011:  return {63'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// expected retire record, regs is the shadow register file and is updated
function automatic rv_pkg::retire_t ref_retire(input rv_pkg::inst_t inst,
                                               input rv_pkg::xlen_t pc,
                                               inout rv_pkg::xlen_t regs [32]);
  rv_pkg::retire_t r;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic            word;
  logic            alu;
  logic            unsup;
  rv_pkg::xlen_t   imm_i;
  rv_pkg::xlen_t   imm_u;
  f3    = inst[14:12];
  f7    = inst[31:25];
  word  = inst[3];
  alu   = 1'b0;
  unsup = 1'b0;
  imm_i = {{52{inst[31]}}, inst[31:20]};
  imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  r     = '0;
  r.pc  = pc;
  case (inst[6:0])
    7'b0110111: begin
      alu     = 1'b1;
      r.value = imm_u;
    end
    7'b0010111: begin
      alu     = 1'b1;
      r.value = pc + imm_u;
    end
    7'b0010011, 7'b0011011: begin
      case (f3)
        3'b001:  alu = word ? f7 == 7'h00 : inst[31:26] == 6'h00;
        3'b101:  alu = word ? (f7 == 7'h00 || f7 == 7'h20)
                            : (inst[31:26] == 6'h00 || inst[31:26] == 6'h10);
        default: alu = !word || f3 == 3'b000;
      endcase
      r.value = ref_op(f3, f3 == 3'b101 && inst[30], word, regs[inst[19:15]], imm_i);
    end
    7'b0110011, 7'b0111011: begin
      if (f7 == 7'h01) begin
        unsup = !word || f3 == 3'b000 || f3[2];
      end else begin
        alu = (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) &&
              (!word || f3 inside {3'b000, 3'b001, 3'b101});
      end
      r.value = ref_op(f3, f7[5], word, regs[inst[19:15]], regs[inst[24:20]]);
    end
    7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
    7'b1100111, 7'b1110011, 7'b0001111: unsup = 1'b1;
    default: ;
  endcase
  r.inst_class = alu ? rv_pkg::cls_alu : (unsup ? rv_pkg::cls_unsupported : rv_pkg::cls_illegal);
  if (alu) begin
    r.rd_idx = inst[11:7];
    if (r.rd_idx != '0) begin
      regs[r.rd_idx] = r.value;
    end
  end else begin
    r.value = '0;
  end
  return r;
endfunction

// instruction encoders for directed stimulus
function automatic rv_pkg::inst_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                        input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                        input rv_pkg::reg_idx_t rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::inst_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                        input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                        input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::inst_t enc_u(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
                                        input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

`endif

// ==== sim/rv_exec_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_exec_core_tb;
  import rv_pkg::*;

  `include "rv_ref_model.svh"

  localparam int reset_cycles = 16;
  localparam int random_count = 300;

  logic    clk;
  logic    reset;
  logic    inst_valid;
  inst_t   inst_data;
  logic    retire_valid;
  retire_t retire;

  xlen_t   shadow [32];
  retire_t exp_q[$];
  string   name_q[$];
  xlen_t   exp_pc;
  string   test_name;
  int      n_driven;
  int      n_idle;
  int      cycles;
  int      errors;

  rv_exec_core dut0 (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst_data    (inst_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #20 clk = ~clk;

  task automatic fail_stop();
    errors++;
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_class(input string name, input inst_class_e exp,
                             input inst_class_e act);
    if (act !== exp) begin
      $display("error %s: expected %s, actual %s", name, exp.name(), act.name());
      fail_stop();
    end
  endtask

  task automatic check_index(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      $display("error %s: expected x%0d, actual x%0d", name, exp, act);
      fail_stop();
    end
  endtask

  // expected record is computed when the instruction is driven
  task automatic send_inst(input inst_t inst);
    retire_t exp;
    @(negedge clk);
    inst_valid = 1'b1;
    inst_data  = inst;
    exp = ref_retire(inst, exp_pc, shadow);
    exp_q.push_back(exp);
    name_q.push_back(test_name);
    exp_pc += 64'd4;
    n_driven++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      inst_valid = 1'b0;
      n_idle++;
    end
  endtask

  // legal alu encodings only, registers from x0..x7 to get many dependencies
  function automatic inst_t random_alu_inst();
    inst_t       inst;
    logic [2:0]  f3;
    logic [2:0]  f3w;
    logic        alt;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
    f3  = 3'($urandom_range(0, 7));
    f3w = f3[0] ? 3'b101 : (f3[1] ? 3'b001 : 3'b000);
    alt = 1'($urandom_range(0, 1));
    rd  = 5'($urandom_range(0, 7));
    rs1 = 5'($urandom_range(0, 7));
    rs2 = 5'($urandom_range(0, 7));
    imm = 12'($urandom);
    case ($urandom_range(0, 5))
      0: inst = enc_u(20'($urandom), rd, lui);
      1: inst = enc_u(20'($urandom), rd, auipc);
      2: begin
        if (f3 == 3'b001) imm[11:6] = 6'h00;
        if (f3 == 3'b101) imm[11:6] = alt ? 6'h10 : 6'h00;
        inst = enc_i(imm, rs1, f3, rd, op_imm);
      end
      3: begin
        if (f3w == 3'b001) imm[11:5] = 7'h00;
        if (f3w == 3'b101) imm[11:5] = alt ? 7'h20 : 7'h00;
        inst = enc_i(imm, rs1, f3w, rd, op_imm_32);
      end
      4: inst = enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                      rs2, rs1, f3, rd, op);
      default: inst = enc_r((alt && f3w != 3'b001) ? 7'h20 : 7'h00, rs2, rs1, f3w, rd, op_32);
    endcase
    return inst;
  endfunction

  // outputs change on the rising edge, so sample them on the falling one
  always @(negedge clk) begin : compare_retire
    retire_t exp;
    string   name;
    if (!reset && retire_valid !== 1'b0) begin
      if (exp_q.size() == 0) begin
        $display("retire_valid high with no instruction outstanding, pc %h", retire.pc);
        fail_stop();
      end else begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        check_value({name, " pc"}, exp.pc, retire.pc);
        check_class({name, " class"}, exp.inst_class, retire.inst_class);
        check_index({name, " rd"}, exp.rd_idx, retire.rd_idx);
        check_value({name, " value"}, exp.value, retire.value);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > reset_cycles + n_driven + n_idle + 64) begin
      $display("timeout after %0d cycles with %0d retires outstanding", cycles, exp_q.size());
      fail_stop();
    end
  end

  initial begin
    void'($urandom(32'haa49_8ac3));
    clk        = 1'b0;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst_data  = '0;
    exp_pc     = reset_pc;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    test_name = "idle after reset";
    idle_cycles(6);

    test_name = "lui auipc";
    send_inst(enc_u(20'h80000, 5'd1, lui));
    send_inst(enc_u(20'h12345, 5'd2, lui));
    send_inst(enc_i(12'h678, 5'd2, 3'b000, 5'd2, op_imm));
    send_inst(enc_u(20'h00001, 5'd3, auipc));
    send_inst(enc_u(20'hfffff, 5'd4, auipc));

    test_name = "op-imm";
    send_inst(enc_i(12'hfff, 5'd1, 3'b000, 5'd5, op_imm));
    send_inst(enc_i(12'h800, 5'd0, 3'b000, 5'd6, op_imm));
    send_inst(enc_i(12'hfff, 5'd5, 3'b010, 5'd7, op_imm));
    send_inst(enc_i(12'h005, 5'd6, 3'b011, 5'd8, op_imm));
    send_inst(enc_i(12'hf0f, 5'd2, 3'b100, 5'd9, op_imm));
    send_inst(enc_i(12'hff0, 5'd2, 3'b110, 5'd10, op_imm));
    send_inst(enc_i(12'h7ff, 5'd1, 3'b111, 5'd11, op_imm));
    send_inst(enc_i(12'd40, 5'd2, 3'b001, 5'd12, op_imm));
    send_inst(enc_i(12'd33, 5'd1, 3'b101, 5'd13, op_imm));
    send_inst(enc_i(12'h424, 5'd1, 3'b101, 5'd14, op_imm));

    test_name = "op register";
    for (int f = 0; f < 8; f++) begin
      send_inst(enc_r(7'h00, 5'd2, 5'd5, 3'(f), 5'(16 + f), op));
    end
    send_inst(enc_r(7'h20, 5'd2, 5'd5, 3'b000, 5'd16, op));
    send_inst(enc_r(7'h20, 5'd14, 5'd1, 3'b101, 5'd17, op));

    test_name = "word";
    send_inst(enc_i(12'h7ff, 5'd2, 3'b000, 5'd24, op_imm_32));
    send_inst(enc_u(20'h7ffff, 5'd25, lui));
    send_inst(enc_i(12'h7ff, 5'd25, 3'b000, 5'd25, op_imm_32));
    send_inst(enc_r(7'h00, 5'd25, 5'd25, 3'b000, 5'd26, op_32));
    send_inst(enc_r(7'h20, 5'd25, 5'd1, 3'b000, 5'd27, op_32));
    send_inst(enc_r(7'h00, 5'd13, 5'd2, 3'b001, 5'd28, op_32));
    send_inst(enc_r(7'h00, 5'd14, 5'd1, 3'b101, 5'd29, op_32));
    send_inst(enc_r(7'h20, 5'd6, 5'd1, 3'b101, 5'd30, op_32));
    send_inst(enc_i(12'd4, 5'd25, 3'b001, 5'd31, op_imm_32));
    send_inst(enc_i(12'd7, 5'd1, 3'b101, 5'd31, op_imm_32));
    send_inst(enc_i(12'h41f, 5'd1, 3'b101, 5'd31, op_imm_32));

    test_name = "bypass chain";
    send_inst(enc_i(12'd7, 5'd0, 3'b000, 5'd1, op_imm));
    for (int i = 2; i < 10; i++) begin
      send_inst(enc_r(7'h00, 5'(i - 1), 5'(i - 1), 3'b000, 5'(i), op));
    end
    send_inst(enc_i(12'd5, 5'd1, 3'b000, 5'd0, op_imm));
    send_inst(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd10, op));

    test_name = "unsupported";
    send_inst(enc_i(12'h010, 5'd1, 3'b011, 5'd12, load));
    send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd4, store));
    send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd8, branch));
    send_inst(enc_u(20'h00100, 5'd12, jal));
    send_inst(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd12, op));
    send_inst(enc_r(7'h00, 5'd0, 5'd12, 3'b000, 5'd13, op));

    test_name = "illegal";
    send_inst(enc_i(12'h000, 5'd0, 3'b000, 5'd1, 7'b1111111));
    send_inst(enc_r(7'h10, 5'd2, 5'd1, 3'b000, 5'd3, op));
    send_inst(enc_r(7'h00, 5'd0, 5'd3, 3'b000, 5'd14, op));
    idle_cycles(3);

    test_name = "random";
    for (int n = 0; n < random_count; n++) begin
      send_inst(random_alu_inst());
      if ($urandom_range(0, 3) == 0) begin
        idle_cycles(int'($urandom_range(1, 3)));
      end
    end
    idle_cycles(1);

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    idle_cycles(4);

    if (errors == 0) begin
      $display("test passed");
      $finish;
    end else begin
      fail_stop();
    end
  end

endmodule

`default_nettype wire
